// ==== Makefile ====
TOP := fsqrt_tb

sim:
	verilator --binary --timing --timescale 1ns/1ns --top-module $(TOP) \
		-f fsqrt.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== dv/fsqrt_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fsqrt_consts.svh"

module fsqrt_checker
    import fp_format_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,
    input  wire              in_valid,
    input  wire float_word_t radicand,
    input  wire              out_valid,
    input  wire float_word_t result,
    output int               err_count,
    output int               checked
);

    string       test_name;
    logic [63:0] expect_q [$];   // {radicand, expected result}
    logic [63:0] entry;

    // Floor square root found bit by bit from the top, squared and compared
    function automatic float_word_t model_sqrt(float_word_t x);
        exp_field_t  e;
        logic [8:0]  e_sum;
        logic [63:0] aligned;
        logic [63:0] r;
        logic [63:0] t;
        e       = x[30:23];
        e_sum   = {1'b0, e} + 9'(`FSQRT_EXP_BIAS);
        aligned = {40'b0, 1'b1, x[22:0]} << (e[0] ? 23 : 24);
        r       = '0;
        for (int b = `FSQRT_ROOT_W - 1; b >= 0; b--) begin
            t = r | (64'd1 << b);
            if (t * t <= aligned) begin
                r = t;
            end
        end
        return {1'b0, e_sum[8:1], r[22:0]};
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            expect_q.delete();
        end else if (in_valid) begin
            expect_q.push_back({radicand, model_sqrt(radicand)});
        end
    end

    // Outputs settle after the rising edge, so compare on the falling one
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            if (expect_q.size() == 0) begin
                err_count++;
                $display("unexpected out_valid with no operand outstanding in %s", test_name);
            end else begin
                entry = expect_q.pop_front();
                checked++;
                if (result !== entry[31:0]) begin
                    err_count++;
                    $display("MISMATCH %s: expected %h actual %h radicand %h",
                             test_name, entry[31:0], result, entry[63:32]);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/fsqrt_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fsqrt_consts.svh"

module fsqrt_tb
    import fp_format_pkg::*;
();

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    float_word_t radicand;
    logic        out_valid;
    float_word_t result;

    int     chk_errors;
    int     chk_checked;
    int     tb_errors;
    int     sent;
    int     tests;
    int     err_mark;
    int     sent_mark;
    int     chk_mark;
    int     cycles;
    integer seed;
    string  test_name;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    fsqrt_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .radicand  (radicand),
        .out_valid (out_valid),
        .result    (result)
    );

    fsqrt_checker chk_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .radicand  (radicand),
        .out_valid (out_valid),
        .result    (result),
        .err_count (chk_errors),
        .checked   (chk_checked)
    );

    function automatic float_word_t rand_word();
        exp_field_t  e;
        frac_field_t f;
        e = exp_field_t'(1 + ($unsigned($random(seed)) % 254));   // Normal range only
        f = frac_field_t'($random(seed));
        return {1'b0, e, f};
    endfunction

    task automatic send(input float_word_t word);
        in_valid = 1'b1;
        radicand = word;
        sent++;
        @(negedge clk);
    endtask

    task automatic idle(input int n);
        in_valid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    task automatic check_idle(input bit with_result);
        if (out_valid !== 1'b0) begin
            tb_errors++;
            $display("MISMATCH %s: expected out_valid 0 actual %b", test_name, out_valid);
        end
        if (with_result && result !== '0) begin
            tb_errors++;
            $display("MISMATCH %s: expected %h actual %h", test_name, 32'h0, result);
        end
    endtask

    // Sends one operand alone and counts falling edges until its result shows up
    task automatic single(input float_word_t word, input float_word_t expected);
        send(word);
        in_valid = 1'b0;
        cycles = 1;
        while (!out_valid && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        if (!out_valid) begin
            tb_errors++;
            $display("timeout: no result for radicand %h in %s", word, test_name);
        end else if (result !== expected) begin
            tb_errors++;
            $display("MISMATCH %s: expected %h actual %h", test_name, expected, result);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        chk_i.test_name = name;
        err_mark = tb_errors + chk_errors;
        sent_mark = sent;
        chk_mark = chk_checked;
    endtask

    task automatic end_test();
        int wait_cnt;
        in_valid = 1'b0;
        wait_cnt = 0;
        while (chk_checked < sent && wait_cnt < 1000) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (chk_checked < sent) begin
            tb_errors++;
            $display("timeout: %s got %0d of %0d results", test_name,
                     chk_checked - chk_mark, sent - sent_mark);
        end
        repeat (`FSQRT_LATENCY + 2) @(negedge clk);   // Catch stray pulses
        if (chk_checked - chk_mark != sent - sent_mark) begin
            tb_errors++;
            $display("MISMATCH %s: expected %0d results actual %0d", test_name,
                     sent - sent_mark, chk_checked - chk_mark);
        end
        tests++;
        $display("%-14s results %0d errors %0d", test_name, chk_checked - chk_mark,
                 tb_errors + chk_errors - err_mark);
    endtask

    initial begin
        seed = 32'h62ae_2484;
        rst_n = 1'b0;
        in_valid = 1'b0;
        radicand = '0;

        start_test("reset_idle");
        repeat (16) begin
            @(negedge clk);
            check_idle(1'b1);
        end
        rst_n = 1'b1;
        // Data registers fill from the idle radicand once the pipeline has flushed
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_idle(i < `FSQRT_STAGES);
        end
        end_test();

        start_test("exact_squares");
        single(32'h4080_0000, 32'h4000_0000);
        single(32'h4010_0000, 32'h3fc0_0000);
        single(32'h3f80_0000, 32'h3f80_0000);
        single(32'h3e80_0000, 32'h3f00_0000);
        single(32'h4180_0000, 32'h4080_0000);
        end_test();

        start_test("latency");
        single(32'h4080_0000, 32'h4000_0000);
        if (cycles != `FSQRT_LATENCY) begin
            tb_errors++;
            $display("MISMATCH latency: expected %0d actual %0d", `FSQRT_LATENCY, cycles);
        end
        end_test();

        start_test("random_stream");
        repeat (300) send(rand_word());
        end_test();

        start_test("random_gaps");
        repeat (300) begin
            send(rand_word());
            idle($unsigned($random(seed)) % 4);
        end
        end_test();

        start_test("extremes");
        send({1'b0, 8'd1, 23'h000000});
        send({1'b0, 8'd1, 23'h7fffff});
        send({1'b0, 8'd2, 23'h000000});
        send({1'b0, 8'd2, 23'h7fffff});
        send({1'b0, 8'd253, 23'h000000});
        send({1'b0, 8'd253, 23'h7fffff});
        send({1'b0, 8'd254, 23'h000000});
        send({1'b0, 8'd254, 23'h7fffff});
        end_test();

        $display("tests %0d, results checked %0d, errors %0d", tests, chk_checked,
                 tb_errors + chk_errors);
        if (tb_errors + chk_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fsqrt.f ====
+incdir+hw
hw/fp_format_pkg.sv
hw/sqrt_recur_pkg.sv
hw/pipe_delay.sv
hw/exp_path.sv
hw/root_stage.sv
hw/root_path.sv
hw/result_pack.sv
hw/fsqrt_top.sv
dv/fsqrt_checker.sv
dv/fsqrt_tb.sv

// ==== hw/exp_path.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fsqrt_consts.svh"

module exp_path
    import fp_format_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,
    input  wire float_word_t radicand,
    output exp_field_t       exp_out
);

    localparam logic [`FSQRT_EXP_W:0] BIAS = `FSQRT_EXP_BIAS;

    exp_field_t             exp_f;
    logic [`FSQRT_EXP_W:0]  exp_sum;   // One spare bit for the carry
    exp_field_t             exp_half;

    assign exp_f = radicand[`FSQRT_WORD_W-2 -: `FSQRT_EXP_W];

    // (e + bias) / 2 covers both odd and even true exponents
    assign exp_sum  = {1'b0, exp_f} + BIAS;
    assign exp_half = exp_sum[`FSQRT_EXP_W:1];

    pipe_delay #(
        .payload_t (exp_field_t),
        .DEPTH     (`FSQRT_STAGES)
    ) exp_dly_i (
        .clk   (clk),
        .rst_n (rst_n),
        .din   (exp_half),
        .dout  (exp_out)
    );

endmodule

`default_nettype wire

// ==== hw/fp_format_pkg.sv ====
`default_nettype none

`include "fsqrt_consts.svh"

package fp_format_pkg;

    // Raw IEEE-754 single word with the sign at the top
    typedef logic [`FSQRT_WORD_W-1:0] float_word_t;

    typedef logic [`FSQRT_EXP_W-1:0]  exp_field_t;   // Biased exponent
    typedef logic [`FSQRT_FRAC_W-1:0] frac_field_t;  // Stored fraction without hidden bit

endpackage

`default_nettype wire

// ==== hw/fsqrt_consts.svh ====
`ifndef FSQRT_CONSTS_SVH
`define FSQRT_CONSTS_SVH

// Single-precision word layout
`define FSQRT_WORD_W          32
`define FSQRT_EXP_W           8
`define FSQRT_FRAC_W          23
`define FSQRT_EXP_BIAS        127

// Root recurrence
`define FSQRT_ROOT_W          24    // Includes hidden one
`define FSQRT_BITS_PER_STAGE  2
`define FSQRT_STAGES          12

// Root stages plus the output register from input strobe to output pulse
`define FSQRT_LATENCY         13

`endif

// ==== hw/fsqrt_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fsqrt_consts.svh"

module fsqrt_top
    import fp_format_pkg::*;
    import sqrt_recur_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,
    input  wire              in_valid,
    input  wire float_word_t radicand,
    output logic             out_valid,
    output float_word_t      result
);

    exp_field_t exp_out;
    root_t      root;
    logic       stage_valid;

    exp_path exp_path_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .radicand (radicand),
        .exp_out  (exp_out)
    );

    root_path root_path_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .radicand (radicand),
        .root     (root)
    );

    // Valid travels alongside the root stages
    pipe_delay #(
        .payload_t (logic),
        .DEPTH     (`FSQRT_STAGES)
    ) valid_dly_i (
        .clk   (clk),
        .rst_n (rst_n),
        .din   (in_valid),
        .dout  (stage_valid)
    );

    result_pack result_pack_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .stage_valid (stage_valid),
        .exp_in      (exp_out),
        .root        (root),
        .out_valid   (out_valid),
        .result      (result)
    );

endmodule

`default_nettype wire

// ==== hw/pipe_delay.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipe_delay #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  wire           clk,
    input  wire           rst_n,
    input  wire payload_t din,
    output payload_t      dout
);

    payload_t taps [DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                taps[i] <= '0;
            end
        end else begin
            taps[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                taps[i] <= taps[i-1];
            end
        end
    end

    assign dout = taps[DEPTH-1];

endmodule

`default_nettype wire

// ==== hw/result_pack.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fsqrt_consts.svh"

module result_pack
    import fp_format_pkg::*;
    import sqrt_recur_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,
    input  wire             stage_valid,
    input  wire exp_field_t exp_in,
    input  wire root_t      root,
    output logic            out_valid,
    output float_word_t     result
);

    frac_field_t frac_w;

    assign frac_w = root[`FSQRT_FRAC_W-1:0];   // Hidden one dropped

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= stage_valid;
            result    <= {1'b0, exp_in, frac_w};   // Root is never negative
        end
    end

endmodule

`default_nettype wire

// ==== hw/root_path.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fsqrt_consts.svh"

module root_path
    import fp_format_pkg::*;
    import sqrt_recur_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,
    input  wire float_word_t radicand,
    output root_t            root
);

    exp_field_t  exp_f;
    frac_field_t frac_f;
    root_t       mant;
    rad_bits_t   rad_aligned;

    // Chain taps with index 0 feeding stage 0
    rem_t      rem_q  [`FSQRT_STAGES+1];
    root_t     root_q [`FSQRT_STAGES+1];
    rad_bits_t rad_q  [`FSQRT_STAGES+1];

    assign {exp_f, frac_f} = radicand[`FSQRT_WORD_W-2:0];
    assign mant = {1'b1, frac_f};

    // Odd biased field means even true exponent, so one less shift
    assign rad_aligned = exp_f[0] ? rad_bits_t'(mant) << (`FSQRT_ROOT_W - 1)
                                  : rad_bits_t'(mant) << `FSQRT_ROOT_W;

    assign rem_q[0]  = '0;
    assign root_q[0] = '0;
    assign rad_q[0]  = rad_aligned;

    for (genvar s = 0; s < `FSQRT_STAGES; s++) begin : g_stage
        root_stage #(
            .STAGE (s)
        ) stage_i (
            .clk      (clk),
            .rst_n    (rst_n),
            .rem_in   (rem_q[s]),
            .root_in  (root_q[s]),
            .rad_in   (rad_q[s]),
            .rem_out  (rem_q[s+1]),
            .root_out (root_q[s+1]),
            .rad_out  (rad_q[s+1])
        );
    end

    assign root = root_q[`FSQRT_STAGES];

endmodule

`default_nettype wire

// ==== hw/root_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fsqrt_consts.svh"

module root_stage
    import sqrt_recur_pkg::*;
#(
    parameter int STAGE = 0
) (
    input  wire            clk,
    input  wire            rst_n,
    input  wire rem_t      rem_in,
    input  wire root_t     root_in,
    input  wire rad_bits_t rad_in,
    output rem_t           rem_out,
    output root_t          root_out,
    output rad_bits_t      rad_out
);

    // Highest root bit this stage decides
    localparam int HI    = `FSQRT_ROOT_W - 1 - `FSQRT_BITS_PER_STAGE * STAGE;
    localparam int REM_W = $bits(rem_t);
    localparam int RAD_W = $bits(rad_bits_t);

    rem_t      rem_c;
    rem_t      shl_c;
    root_t     root_c;
    root_t     q_c;
    rad_bits_t rad_c;

    always_comb begin
        rem_c  = rem_in;
        root_c = root_in;
        rad_c  = rad_in;
        for (int k = 0; k < `FSQRT_BITS_PER_STAGE; k++) begin
            q_c   = root_c >> (HI - k + 1);   // Right-aligned bits decided so far
            shl_c = {rem_c[REM_W-3:0], rad_c[RAD_W-1 -: 2]};
            // Negative remainder adds 4q+3, otherwise subtracts 4q+1
            if (rem_c[REM_W-1]) begin
                rem_c = shl_c + {q_c, 2'b11};
            end else begin
                rem_c = shl_c - {q_c, 2'b01};
            end
            root_c[HI - k] = ~rem_c[REM_W-1];
            rad_c          = rad_c << 2;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rem_out  <= '0;
            root_out <= '0;
            rad_out  <= '0;
        end else begin
            rem_out  <= rem_c;
            root_out <= root_c;
            rad_out  <= rad_c;
        end
    end

endmodule

`default_nettype wire

// ==== hw/sqrt_recur_pkg.sv ====
`default_nettype none

`include "fsqrt_consts.svh"

package sqrt_recur_pkg;

    // Root under construction with the hidden bit at the top
    typedef logic [`FSQRT_ROOT_W-1:0] root_t;

    // Partial remainder needs two bits above the root width
    typedef logic signed [`FSQRT_ROOT_W+1:0] rem_t;

    // Aligned radicand consumed two bits at a time from the top
    typedef logic [2*`FSQRT_ROOT_W-1:0] rad_bits_t;

endpackage

`default_nettype wire
